// File: rtl/mm_ram_pkg.sv
package mm_ram_pkg;

    // ------------------------------------------------------------
    // widths
    // ------------------------------------------------------------

    // 4 KiB of byte addressed RAM
    localparam int RAM_ADDR_WIDTH = 12;
    // debug window size as a power of two, placed at the top of RAM
    localparam int DBG_ADDR_WIDTH = 8;
    // fetch width of the instruction port
    localparam int INSTR_RDATA_WIDTH = 128;
    localparam int DATA_WIDTH = 32;
    localparam int IRQ_WIDTH = 32;

    // ------------------------------------------------------------
    // address map of the pseudo peripherals
    // ------------------------------------------------------------

    // test status and exit
    localparam logic [31:0] MMADDR_TESTSTATUS = 32'h2000_0000;
    localparam logic [31:0] MMADDR_EXIT = 32'h2000_0004;

    // interrupt timer, mask first then count-down value
    localparam logic [31:0] MMADDR_TIMERREG = 32'h1500_0000;
    localparam logic [31:0] MMADDR_TIMERVAL = 32'h1500_0004;

    // debug request generator control
    localparam logic [31:0] MMADDR_DBG = 32'h1500_0008;

    // cycle counter, read returns count, write clears
    localparam logic [31:0] MMADDR_TICKS = 32'h1500_1004;

    // ------------------------------------------------------------
    // magic values written to the test status register
    // ------------------------------------------------------------

    localparam logic [31:0] TEST_PASS_VALUE = 32'd123456789;
    localparam logic [31:0] TEST_FAIL_VALUE = 32'd1;

    // ------------------------------------------------------------
    // debug control word layout
    // ------------------------------------------------------------

    // level applied to debug_req once the delay runs out
    localparam int DBG_VALUE_BIT = 31;
    // 1 = pulse, 0 = level
    localparam int DBG_PULSE_BIT = 30;
    // pulse duration in cycles
    localparam int DBG_DUR_LSB = 16;
    localparam int DBG_DUR_MSB = 28;
    // start delay in cycles
    localparam int DBG_DLY_LSB = 0;
    localparam int DBG_DLY_MSB = 14;

endpackage

// File: rtl/dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram (
    input  logic                                     clk_i,

    // instruction port, read only and aligned to the fetch width
    input  logic                                     instr_req_i,
    input  logic [mm_ram_pkg::RAM_ADDR_WIDTH-1:0]    instr_addr_i,
    output logic                                     instr_gnt_o,
    output logic [mm_ram_pkg::INSTR_RDATA_WIDTH-1:0] instr_rdata_o,
    output logic                                     instr_rvalid_o,

    // data port, word aligned with byte enables
    input  logic                                     data_req_i,
    input  logic [mm_ram_pkg::RAM_ADDR_WIDTH-1:0]    data_addr_i,
    input  logic                                     data_we_i,
    input  logic [3:0]                               data_be_i,
    input  logic [mm_ram_pkg::DATA_WIDTH-1:0]        data_wdata_i,
    output logic [mm_ram_pkg::DATA_WIDTH-1:0]        data_rdata_o
);

    logic [7:0] mem [2**mm_ram_pkg::RAM_ADDR_WIDTH];

    // the memory never stalls a fetch
    assign instr_gnt_o = instr_req_i;

    // fetch reads a whole aligned line of bytes
    always_ff @(posedge clk_i) begin
        instr_rvalid_o <= instr_req_i;
        if (instr_req_i) begin
            for (int i = 0; i < mm_ram_pkg::INSTR_RDATA_WIDTH / 8; i++) begin
                instr_rdata_o[8*i +: 8] <= mem[{instr_addr_i[mm_ram_pkg::RAM_ADDR_WIDTH-1:4],
                                                4'(i)}];
            end
        end
    end

    // data access, write merges enabled bytes, read returns the word
    always_ff @(posedge clk_i) begin
        if (data_req_i) begin
            for (int i = 0; i < 4; i++) begin
                if (data_we_i && data_be_i[i]) begin
                    mem[{data_addr_i[mm_ram_pkg::RAM_ADDR_WIDTH-1:2], 2'(i)}] <=
                        data_wdata_i[8*i +: 8];
                end
            end
            if (!data_we_i) begin
                for (int i = 0; i < 4; i++) begin
                    data_rdata_o[8*i +: 8] <=
                        mem[{data_addr_i[mm_ram_pkg::RAM_ADDR_WIDTH-1:2], 2'(i)}];
                end
            end
        end
    end

endmodule

// File: rtl/mm_decode.sv
`timescale 1ns/1ps

module mm_decode (
    input  logic                                  clk_i,
    input  logic                                  rst_ni,
    input  logic [31:0]                           dm_halt_addr_i,

    // data port from the core
    input  logic                                  data_req_i,
    input  logic [31:0]                           data_addr_i,
    input  logic                                  data_we_i,
    input  logic [3:0]                            data_be_i,
    input  logic [mm_ram_pkg::DATA_WIDTH-1:0]     data_wdata_i,
    output logic                                  data_gnt_o,
    output logic [mm_ram_pkg::DATA_WIDTH-1:0]     data_rdata_o,
    output logic                                  data_rvalid_o,

    // RAM data port
    output logic                                  ram_req_o,
    output logic [mm_ram_pkg::RAM_ADDR_WIDTH-1:0] ram_addr_o,
    output logic                                  ram_we_o,
    output logic [3:0]                            ram_be_o,
    output logic [mm_ram_pkg::DATA_WIDTH-1:0]     ram_wdata_o,
    input  logic [mm_ram_pkg::DATA_WIDTH-1:0]     ram_rdata_i,

    // peripheral strobes and read back
    input  logic [mm_ram_pkg::DATA_WIDTH-1:0]     ticks_i,
    output logic                                  timer_mask_we_o,
    output logic                                  timer_val_we_o,
    output logic                                  ticks_clear_o,
    output logic                                  dbg_we_o,
    output logic [mm_ram_pkg::DATA_WIDTH-1:0]     wr_data_o,

    // test status
    output logic                                  tests_passed_o,
    output logic                                  tests_failed_o,
    output logic                                  exit_valid_o,
    output logic [31:0]                           exit_value_o
);

    logic [31:0]                           dbg_offset;
    logic                                  dbg_hit;
    logic                                  ram_hit;
    logic                                  rd_req;
    logic                                  wr_req;
    logic                                  rd_ram_q;
    logic                                  rvalid_q;
    logic [mm_ram_pkg::DATA_WIDTH-1:0]     periph_rdata_q;

    // ------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------

    // every request is granted at once
    assign data_gnt_o = data_req_i;
    assign rd_req     = data_req_i && !data_we_i;
    assign wr_req     = data_req_i && data_we_i;

    // debug window starts at dm_halt_addr_i and lands at the top of RAM
    assign dbg_offset = data_addr_i - dm_halt_addr_i;
    assign dbg_hit    = (data_addr_i >= dm_halt_addr_i) &&
                        (dbg_offset[31:mm_ram_pkg::DBG_ADDR_WIDTH] == '0);
    assign ram_hit    = dbg_hit || (data_addr_i[31:mm_ram_pkg::RAM_ADDR_WIDTH] == '0);

    assign ram_req_o   = data_req_i && ram_hit;
    assign ram_we_o    = data_we_i;
    assign ram_be_o    = data_be_i;
    assign ram_wdata_o = data_wdata_i;

    // the debug window takes priority over the plain RAM range
    always_comb begin
        if (dbg_hit) begin
            ram_addr_o = {{(mm_ram_pkg::RAM_ADDR_WIDTH - mm_ram_pkg::DBG_ADDR_WIDTH){1'b1}},
                          dbg_offset[mm_ram_pkg::DBG_ADDR_WIDTH-1:0]};
        end else begin
            ram_addr_o = data_addr_i[mm_ram_pkg::RAM_ADDR_WIDTH-1:0];
        end
    end

    // ------------------------------------------------------------
    // peripheral writes
    // ------------------------------------------------------------

    assign wr_data_o       = data_wdata_i;
    assign timer_mask_we_o = wr_req && !ram_hit && (data_addr_i == mm_ram_pkg::MMADDR_TIMERREG);
    assign timer_val_we_o  = wr_req && !ram_hit && (data_addr_i == mm_ram_pkg::MMADDR_TIMERVAL);
    assign ticks_clear_o   = wr_req && !ram_hit && (data_addr_i == mm_ram_pkg::MMADDR_TICKS);
    assign dbg_we_o        = wr_req && !ram_hit && (data_addr_i == mm_ram_pkg::MMADDR_DBG);

    // status flags live only in the cycle of the write
    always_comb begin
        tests_passed_o = 1'b0;
        tests_failed_o = 1'b0;
        exit_valid_o   = 1'b0;
        exit_value_o   = '0;
        if (wr_req && !ram_hit) begin
            if (data_addr_i == mm_ram_pkg::MMADDR_TESTSTATUS) begin
                tests_passed_o = (data_wdata_i == mm_ram_pkg::TEST_PASS_VALUE);
                tests_failed_o = (data_wdata_i == mm_ram_pkg::TEST_FAIL_VALUE);
            end
            if (data_addr_i == mm_ram_pkg::MMADDR_EXIT) begin
                exit_valid_o = 1'b1;
                exit_value_o = data_wdata_i;
            end
        end
    end

    // ------------------------------------------------------------
    // response path
    // ------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
            rd_ram_q <= 1'b0;
        end else begin
            rvalid_q <= data_req_i;
            rd_ram_q <= rd_req && ram_hit;
        end
    end

    // tick value sampled at the grant edge, unmapped reads give zero
    always_ff @(posedge clk_i) begin
        if (rd_req && !ram_hit) begin
            periph_rdata_q <= (data_addr_i == mm_ram_pkg::MMADDR_TICKS) ? ticks_i : '0;
        end
    end

    assign data_rvalid_o = rvalid_q;
    assign data_rdata_o  = rd_ram_q ? ram_rdata_i : periph_rdata_q;

endmodule

// File: rtl/sys_timer.sv
`timescale 1ns/1ps

module sys_timer (
    input  logic                              clk_i,
    input  logic                              rst_ni,

    // register writes from the decoder
    input  logic                              mask_we_i,
    input  logic                              val_we_i,
    input  logic                              clear_i,
    input  logic [mm_ram_pkg::DATA_WIDTH-1:0] wr_data_i,

    // interrupt interface of the core
    input  logic                              irq_ack_i,
    input  logic [4:0]                        irq_id_i,
    output logic [mm_ram_pkg::IRQ_WIDTH-1:0]  irq_o,

    output logic [mm_ram_pkg::DATA_WIDTH-1:0] ticks_o
);

    logic [mm_ram_pkg::IRQ_WIDTH-1:0]  mask_q;
    logic [mm_ram_pkg::DATA_WIDTH-1:0] cnt_q;
    logic [mm_ram_pkg::IRQ_WIDTH-1:0]  irq_q;
    logic [mm_ram_pkg::DATA_WIDTH-1:0] ticks_q;

    // ------------------------------------------------------------
    // interrupt timer
    // ------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q <= '0;
            cnt_q  <= '0;
            irq_q  <= '0;
        end else begin
            if (mask_we_i) begin
                mask_q <= wr_data_i[mm_ram_pkg::IRQ_WIDTH-1:0];
            end

            // a new value restarts the count, zero stops it
            if (val_we_i) begin
                cnt_q <= wr_data_i;
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end

            // fire on the last count, acknowledge drops one bit
            if (cnt_q == 32'd1) begin
                irq_q <= mask_q;
            end else if (irq_ack_i) begin
                irq_q[irq_id_i] <= 1'b0;
            end
        end
    end

    assign irq_o = irq_q;

    // free running cycle counter
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ticks_q <= '0;
        end else if (clear_i) begin
            ticks_q <= '0;
        end else begin
            ticks_q <= ticks_q + 1'b1;
        end
    end

    assign ticks_o = ticks_q;

endmodule

// File: rtl/debug_req_gen.sv
`timescale 1ns/1ps

module debug_req_gen (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              we_i,
    input  logic [mm_ram_pkg::DATA_WIDTH-1:0] wr_data_i,
    output logic                              debug_req_o
);

    logic [mm_ram_pkg::DBG_DLY_MSB-mm_ram_pkg::DBG_DLY_LSB:0] dly_load;
    logic [mm_ram_pkg::DBG_DUR_MSB-mm_ram_pkg::DBG_DUR_LSB:0] dur_load;
    logic [mm_ram_pkg::DBG_DLY_MSB-mm_ram_pkg::DBG_DLY_LSB:0] start_cnt_q;
    logic [mm_ram_pkg::DBG_DUR_MSB-mm_ram_pkg::DBG_DUR_LSB:0] dur_cnt_q;
    logic                                                     value_q;
    logic                                                     idle;

    // ------------------------------------------------------------
    // control word decode
    // ------------------------------------------------------------

    always_comb begin
        dly_load = wr_data_i[mm_ram_pkg::DBG_DLY_MSB:mm_ram_pkg::DBG_DLY_LSB];
        dur_load = wr_data_i[mm_ram_pkg::DBG_DUR_MSB:mm_ram_pkg::DBG_DUR_LSB];

        // a zero field counts as one cycle
        if (dly_load == '0) begin
            dly_load[0] = 1'b1;
        end
        if (dur_load == '0) begin
            dur_load[0] = 1'b1;
        end

        // level mode has no release phase
        if (!wr_data_i[mm_ram_pkg::DBG_PULSE_BIT]) begin
            dur_load = '0;
        end
    end

    assign idle = (start_cnt_q == '0) && (dur_cnt_q == '0);

    // ------------------------------------------------------------
    // delay then pulse sequencer
    // ------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            start_cnt_q <= '0;
            dur_cnt_q   <= '0;
            value_q     <= 1'b0;
            debug_req_o <= 1'b0;
        end else if (we_i && idle) begin
            // writes while busy are dropped
            start_cnt_q <= dly_load;
            dur_cnt_q   <= dur_load;
            value_q     <= wr_data_i[mm_ram_pkg::DBG_VALUE_BIT];
        end else if (start_cnt_q != '0) begin
            start_cnt_q <= start_cnt_q - 1'b1;
            if (start_cnt_q == 1) begin
                debug_req_o <= value_q;
            end
        end else if (dur_cnt_q != '0) begin
            dur_cnt_q <= dur_cnt_q - 1'b1;
            if (dur_cnt_q == 1) begin
                debug_req_o <= !value_q;
            end
        end
    end

endmodule

// File: rtl/mm_ram.sv
`timescale 1ns/1ps

module mm_ram (
    input  logic                                     clk_i,
    input  logic                                     rst_ni,
    input  logic [31:0]                              dm_halt_addr_i,

    input  logic                                     instr_req_i,
    input  logic [31:0]                              instr_addr_i,
    output logic                                     instr_gnt_o,
    output logic [mm_ram_pkg::INSTR_RDATA_WIDTH-1:0] instr_rdata_o,
    output logic                                     instr_rvalid_o,

    input  logic                                     data_req_i,
    input  logic [31:0]                              data_addr_i,
    input  logic                                     data_we_i,
    input  logic [3:0]                               data_be_i,
    input  logic [mm_ram_pkg::DATA_WIDTH-1:0]        data_wdata_i,
    output logic                                     data_gnt_o,
    output logic [mm_ram_pkg::DATA_WIDTH-1:0]        data_rdata_o,
    output logic                                     data_rvalid_o,

    input  logic [4:0]                               irq_id_i,
    input  logic                                     irq_ack_i,
    output logic [mm_ram_pkg::IRQ_WIDTH-1:0]         irq_o,

    output logic                                     debug_req_o,

    output logic                                     tests_passed_o,
    output logic                                     tests_failed_o,
    output logic                                     exit_valid_o,
    output logic [31:0]                              exit_value_o
);

    logic [31:0]                           instr_offset;
    logic                                  instr_dbg_hit;
    logic [mm_ram_pkg::RAM_ADDR_WIDTH-1:0] instr_ram_addr;

    logic                                  ram_req;
    logic [mm_ram_pkg::RAM_ADDR_WIDTH-1:0] ram_addr;
    logic                                  ram_we;
    logic [3:0]                            ram_be;
    logic [mm_ram_pkg::DATA_WIDTH-1:0]     ram_wdata;
    logic [mm_ram_pkg::DATA_WIDTH-1:0]     ram_rdata;

    logic [mm_ram_pkg::DATA_WIDTH-1:0]     ticks;
    logic [mm_ram_pkg::DATA_WIDTH-1:0]     wr_data;
    logic                                  timer_mask_we;
    logic                                  timer_val_we;
    logic                                  ticks_clear;
    logic                                  dbg_we;

    // fetches from the debug module code go to the top of RAM
    assign instr_offset   = instr_addr_i - dm_halt_addr_i;
    assign instr_dbg_hit  = (instr_addr_i >= dm_halt_addr_i) &&
                            (instr_offset[31:mm_ram_pkg::DBG_ADDR_WIDTH] == '0);
    assign instr_ram_addr = instr_dbg_hit ?
        {{(mm_ram_pkg::RAM_ADDR_WIDTH - mm_ram_pkg::DBG_ADDR_WIDTH){1'b1}},
         instr_offset[mm_ram_pkg::DBG_ADDR_WIDTH-1:0]} :
        instr_addr_i[mm_ram_pkg::RAM_ADDR_WIDTH-1:0];

    // ------------------------------------------------------------
    // instances
    // ------------------------------------------------------------

    mm_decode i_mm_decode (
        .clk_i, .rst_ni, .dm_halt_addr_i,
        .data_req_i, .data_addr_i, .data_we_i, .data_be_i, .data_wdata_i,
        .data_gnt_o, .data_rdata_o, .data_rvalid_o,
        .ram_req_o       (ram_req),
        .ram_addr_o      (ram_addr),
        .ram_we_o        (ram_we),
        .ram_be_o        (ram_be),
        .ram_wdata_o     (ram_wdata),
        .ram_rdata_i     (ram_rdata),
        .ticks_i         (ticks),
        .timer_mask_we_o (timer_mask_we),
        .timer_val_we_o  (timer_val_we),
        .ticks_clear_o   (ticks_clear),
        .dbg_we_o        (dbg_we),
        .wr_data_o       (wr_data),
        .tests_passed_o, .tests_failed_o, .exit_valid_o, .exit_value_o
    );

    dual_port_ram i_dual_port_ram (
        .clk_i,
        .instr_req_i,
        .instr_addr_i   (instr_ram_addr),
        .instr_gnt_o, .instr_rdata_o, .instr_rvalid_o,
        .data_req_i     (ram_req),
        .data_addr_i    (ram_addr),
        .data_we_i      (ram_we),
        .data_be_i      (ram_be),
        .data_wdata_i   (ram_wdata),
        .data_rdata_o   (ram_rdata)
    );

    sys_timer i_sys_timer (
        .clk_i, .rst_ni,
        .mask_we_i (timer_mask_we),
        .val_we_i  (timer_val_we),
        .clear_i   (ticks_clear),
        .wr_data_i (wr_data),
        .irq_ack_i, .irq_id_i, .irq_o,
        .ticks_o   (ticks)
    );

    debug_req_gen i_debug_req_gen (
        .clk_i, .rst_ni,
        .we_i      (dbg_we),
        .wr_data_i (wr_data),
        .debug_req_o
    );

endmodule

// File: test/mm_ram_sva.sv
`timescale 1ns/1ps

module mm_ram_sva (
    input logic        clk_i,
    input logic        rst_ni,
    input logic        instr_req_i,
    input logic        instr_gnt_o,
    input logic        instr_rvalid_o,
    input logic        data_req_i,
    input logic [31:0] data_addr_i,
    input logic        data_we_i,
    input logic [31:0] data_wdata_i,
    input logic        data_gnt_o,
    input logic        data_rvalid_o,
    input logic [31:0] irq_o,
    input logic        debug_req_o
);

    logic        mask_wr;
    logic        val_wr;
    logic        dbg_wr;
    logic [31:0] mask_q;
    logic [31:0] irq_n_q;
    logic [31:0] irq_age_q;
    logic        dbg_act_q;
    logic [31:0] dbg_age_q;
    logic [31:0] dbg_word_q;
    logic [31:0] dbg_dly;
    logic [31:0] dbg_dur;
    logic [31:0] dbg_end;
    logic        dbg_busy;

    // ------------------------------------------------------------
    // handshake
    // ------------------------------------------------------------

    assert property (@(posedge clk_i) disable iff (!rst_ni) data_gnt_o == data_req_i)
        else $error("data grant differs from request");
    assert property (@(posedge clk_i) disable iff (!rst_ni) instr_gnt_o == instr_req_i)
        else $error("instruction grant differs from request");
    assert property (@(posedge clk_i) disable iff (!rst_ni) data_req_i |=> data_rvalid_o)
        else $error("data rvalid missing after a grant");
    assert property (@(posedge clk_i) disable iff (!rst_ni) !data_req_i |=> !data_rvalid_o)
        else $error("data rvalid without a grant");
    assert property (@(posedge clk_i) disable iff (!rst_ni) instr_req_i |=> instr_rvalid_o)
        else $error("instruction rvalid missing after a grant");

    // ------------------------------------------------------------
    // peripheral writes seen at the data port
    // ------------------------------------------------------------

    assign mask_wr = data_req_i && data_we_i && (data_addr_i == mm_ram_pkg::MMADDR_TIMERREG);
    assign val_wr  = data_req_i && data_we_i && (data_addr_i == mm_ram_pkg::MMADDR_TIMERVAL);
    assign dbg_wr  = data_req_i && data_we_i && (data_addr_i == mm_ram_pkg::MMADDR_DBG);

    // edges since the last timer value write
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q    <= '0;
            irq_n_q   <= '0;
            irq_age_q <= '0;
        end else begin
            if (mask_wr) begin
                mask_q <= data_wdata_i;
            end
            if (val_wr) begin
                irq_n_q   <= data_wdata_i;
                irq_age_q <= '0;
            end else if (irq_age_q < irq_n_q) begin
                irq_age_q <= irq_age_q + 32'd1;
            end
        end
    end

    // zero delay or duration counts as one cycle
    always_comb begin
        dbg_dly = 32'(dbg_word_q[mm_ram_pkg::DBG_DLY_MSB:mm_ram_pkg::DBG_DLY_LSB]);
        dbg_dur = 32'(dbg_word_q[mm_ram_pkg::DBG_DUR_MSB:mm_ram_pkg::DBG_DUR_LSB]);
        if (dbg_dly == '0) begin
            dbg_dly = 32'd1;
        end
        if (dbg_dur == '0) begin
            dbg_dur = 32'd1;
        end
        dbg_end = dbg_word_q[mm_ram_pkg::DBG_PULSE_BIT] ? dbg_dly + dbg_dur : dbg_dly;
    end

    assign dbg_busy = dbg_act_q && (dbg_age_q < dbg_end);

    // edges since the last accepted debug control write
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            dbg_act_q  <= 1'b0;
            dbg_age_q  <= '0;
            dbg_word_q <= '0;
        end else if (dbg_wr && !dbg_busy) begin
            dbg_act_q  <= 1'b1;
            dbg_age_q  <= '0;
            dbg_word_q <= data_wdata_i;
        end else if (dbg_busy) begin
            dbg_age_q <= dbg_age_q + 32'd1;
        end
    end

    // ------------------------------------------------------------
    // peripheral edge times
    // ------------------------------------------------------------

    // irq takes the mask n edges after a value write of n
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        ((irq_n_q != '0) && (irq_age_q == irq_n_q - 32'd1)) |=> (irq_o == $past(mask_q)))
        else $error("irq did not take the mask at the end of the count");

    // debug request takes the value bit after the start delay
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (dbg_act_q && (dbg_age_q == dbg_dly - 32'd1)) |=>
            (debug_req_o == dbg_word_q[mm_ram_pkg::DBG_VALUE_BIT]))
        else $error("debug request did not start after its delay");

    // pulse mode releases after the duration
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (dbg_act_q && dbg_word_q[mm_ram_pkg::DBG_PULSE_BIT] &&
         (dbg_age_q == dbg_end - 32'd1)) |=>
            (debug_req_o == !dbg_word_q[mm_ram_pkg::DBG_VALUE_BIT]))
        else $error("debug request pulse did not end after its duration");

endmodule

bind mm_ram mm_ram_sva i_mm_ram_sva (
    .clk_i, .rst_ni,
    .instr_req_i, .instr_gnt_o, .instr_rvalid_o,
    .data_req_i, .data_addr_i, .data_we_i, .data_wdata_i,
    .data_gnt_o, .data_rvalid_o,
    .irq_o,
    .debug_req_o
);

// File: test/tb_mm_ram.sv
`timescale 1ns/1ps

module tb_mm_ram;

    localparam int          CYCLE_LIMIT = 2000;
    localparam logic [31:0] SEED        = 32'he87e;
    localparam logic [31:0] HALT_ADDR   = 32'h1a11_0800;

    logic         clk_i = 1'b0;
    logic         rst_ni;
    logic [31:0]  dm_halt_addr_i;
    logic         instr_req_i;
    logic [31:0]  instr_addr_i;
    logic         instr_gnt_o;
    logic [127:0] instr_rdata_o;
    logic         instr_rvalid_o;
    logic         data_req_i;
    logic [31:0]  data_addr_i;
    logic         data_we_i;
    logic [3:0]   data_be_i;
    logic [31:0]  data_wdata_i;
    logic         data_gnt_o;
    logic [31:0]  data_rdata_o;
    logic         data_rvalid_o;
    logic [4:0]   irq_id_i;
    logic         irq_ack_i;
    logic [31:0]  irq_o;
    logic         debug_req_o;
    logic         tests_passed_o;
    logic         tests_failed_o;
    logic         exit_valid_o;
    logic [31:0]  exit_value_o;

    logic [31:0]  rand_state = SEED;
    int           cycles = 0;

    mm_ram i_mm_ram (.*);

    always #2 clk_i = ~clk_i;

    // run limit, the tests need well under half of it
    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout, the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Something failed");
            $fatal(1);
        end
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    task automatic check_eq(input string test, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAIL %s expected %h actual %h", test, exp, act);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic tick(input int n);
        repeat (n) @(posedge clk_i);
        #0.5;
    endtask

    // ------------------------------------------------------------
    // bus tasks, each starts and ends just after a rising edge
    // ------------------------------------------------------------

    task automatic bus_write(input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] wdata);
        data_req_i   = 1'b1;
        data_we_i    = 1'b1;
        data_addr_i  = addr;
        data_be_i    = be;
        data_wdata_i = wdata;
        #1;
        check_eq("write grant", 32'd1, 32'(data_gnt_o));
        tick(1);
        data_req_i = 1'b0;
        check_eq("write rvalid", 32'd1, 32'(data_rvalid_o));
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
        data_req_i  = 1'b1;
        data_we_i   = 1'b0;
        data_addr_i = addr;
        data_be_i   = 4'hf;
        tick(1);
        data_req_i = 1'b0;
        check_eq("read rvalid", 32'd1, 32'(data_rvalid_o));
        rdata = data_rdata_o;
    endtask

    task automatic fetch(input logic [31:0] addr, output logic [127:0] line);
        instr_req_i  = 1'b1;
        instr_addr_i = addr;
        tick(1);
        instr_req_i = 1'b0;
        check_eq("fetch rvalid", 32'd1, 32'(instr_rvalid_o));
        line = instr_rdata_o;
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] be);
        logic [31:0] res;
        res = old_word;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) res[8*i +: 8] = new_word[8*i +: 8];
        end
        return res;
    endfunction

    initial begin
        logic [31:0]  addr;
        logic [31:0]  d0;
        logic [31:0]  d1;
        logic [31:0]  rd;
        logic [3:0]   be;
        logic [127:0] line;
        logic [31:0]  mask;
        int           n;
        int           k;

        rst_ni         = 1'b0;
        dm_halt_addr_i = HALT_ADDR;
        instr_req_i    = 1'b0;
        instr_addr_i   = '0;
        data_req_i     = 1'b0;
        data_addr_i    = '0;
        data_we_i      = 1'b0;
        data_be_i      = '0;
        data_wdata_i   = '0;
        irq_id_i       = '0;
        irq_ack_i      = 1'b0;
        tick(8);
        rst_ni = 1'b1;
        check_eq("reset irq", 32'd0, irq_o);
        check_eq("reset debug_req", 32'd0, 32'(debug_req_o));

        // RAM below the debug window, full word then random byte merge
        for (int i = 0; i < 16; i++) begin
            addr = (next_rand() % 32'h0f00) & ~32'd3;
            d0   = next_rand();
            d1   = next_rand();
            be   = next_rand() >> 7;
            bus_write(addr, 4'hf, d0);
            bus_write(addr, be, d1);
            bus_read(addr, rd);
            check_eq("ram merge", merge_bytes(d0, d1, be), rd);
        end

        // debug window aliases the top of RAM on both ports
        d0 = next_rand();
        bus_write(HALT_ADDR + 32'h10, 4'hf, d0);
        bus_read(32'h0000_0f10, rd);
        check_eq("debug alias", d0, rd);
        fetch(HALT_ADDR + 32'h10, line);
        check_eq("debug fetch", d0, line[31:0]);

        // test status and exit flags in the write cycle
        data_req_i   = 1'b1;
        data_we_i    = 1'b1;
        data_be_i    = 4'hf;
        data_addr_i  = mm_ram_pkg::MMADDR_TESTSTATUS;
        data_wdata_i = mm_ram_pkg::TEST_PASS_VALUE;
        #1;
        check_eq("status pass", 32'd1, 32'(tests_passed_o));
        check_eq("status pass no fail", 32'd0, 32'(tests_failed_o));
        tick(1);
        data_wdata_i = mm_ram_pkg::TEST_FAIL_VALUE;
        #1;
        check_eq("status fail", 32'd1, 32'(tests_failed_o));
        check_eq("status fail no pass", 32'd0, 32'(tests_passed_o));
        tick(1);
        d0           = next_rand();
        data_addr_i  = mm_ram_pkg::MMADDR_EXIT;
        data_wdata_i = d0;
        #1;
        check_eq("exit valid", 32'd1, 32'(exit_valid_o));
        check_eq("exit value", d0, exit_value_o);
        tick(1);
        data_req_i = 1'b0;
        #1;
        check_eq("exit value idle", 32'd0, exit_value_o);
        tick(1);
        bus_read(32'h3000_0000, rd);
        check_eq("unmapped read", 32'd0, rd);

        // timer fires exactly n edges after the value write
        mask = next_rand() | 32'h0000_0008;
        n    = 3 + (next_rand() % 8);
        bus_write(mm_ram_pkg::MMADDR_TIMERREG, 4'hf, mask);
        bus_write(mm_ram_pkg::MMADDR_TIMERVAL, 4'hf, 32'(n));
        tick(n - 1);
        check_eq("irq early", 32'd0, irq_o);
        tick(1);
        check_eq("irq on time", mask, irq_o);
        irq_ack_i = 1'b1;
        irq_id_i  = 5'd3;
        tick(1);
        irq_ack_i = 1'b0;
        check_eq("irq ack", mask & ~32'h0000_0008, irq_o);

        // cycle counter after a clear
        k = 2 + (next_rand() % 12);
        bus_write(mm_ram_pkg::MMADDR_TICKS, 4'hf, 32'd0);
        tick(k - 1);
        bus_read(mm_ram_pkg::MMADDR_TICKS, rd);
        check_eq("ticks", 32'(k - 1), rd);

        // pulse mode with delay 6 and duration 4, second write is dropped
        bus_write(mm_ram_pkg::MMADDR_DBG, 4'hf, 32'hc004_0006);
        bus_write(mm_ram_pkg::MMADDR_DBG, 4'hf, 32'h8000_0001);
        tick(4);
        check_eq("debug before delay", 32'd0, 32'(debug_req_o));
        tick(1);
        check_eq("debug pulse start", 32'd1, 32'(debug_req_o));
        tick(3);
        check_eq("debug pulse held", 32'd1, 32'(debug_req_o));
        tick(1);
        check_eq("debug pulse end", 32'd0, 32'(debug_req_o));

        // level mode keeps its value
        bus_write(mm_ram_pkg::MMADDR_DBG, 4'hf, 32'h8000_0002);
        tick(2);
        check_eq("debug level", 32'd1, 32'(debug_req_o));
        tick(10);
        check_eq("debug level held", 32'd1, 32'(debug_req_o));

        $display("Everything OK");
        $finish;
    end

endmodule

// File: sim.f
rtl/mm_ram_pkg.sv
rtl/dual_port_ram.sv
rtl/mm_decode.sv
rtl/sys_timer.sv
rtl/debug_req_gen.sv
rtl/mm_ram.sv
test/mm_ram_sva.sv
test/tb_mm_ram.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wall
TOP       ?= tb_mm_ram
FILELIST  ?= sim.f
PASS_MSG  := Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -Wall --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
